/* rtl/filter_pkg.sv */
package filter_pkg;

    // ==============================
    // Default sizes of one bank
    // ==============================

    // Number of buckets in the table, always a power of two
    localparam int N_BUCKETS_DEFAULT = 16;

    // Width of one bucket in bits
    localparam int BITS_PER_BUCKET_DEFAULT = 4;

    // Remove requests that can wait for a cycle without an insert
    localparam int REMOVE_FIFO_DEPTH_DEFAULT = 4;

    // ==============================
    // Fixed pipeline depths
    // ==============================

    // Stage of the read-modify-write pipeline that drives the write bus
    // Stage 0 reads, stage 1 merges in-flight masks, stage 2 writes
    localparam int UPD_WRITE_STAGE = 2;

    // Cycles from a lookup request to its result
    localparam int LOOKUP_LATENCY = 2;

endpackage

/* rtl/bucket_ram.sv */
module bucket_ram
#(
    parameter int N_ENTRIES = filter_pkg::N_BUCKETS_DEFAULT,
    parameter int DATA_BITS = filter_pkg::BITS_PER_BUCKET_DEFAULT
)
(
    input  logic                         clk,
    input  logic                         reset,
    output logic                         rdy,
    input  logic                         wr_en,
    input  logic [$clog2(N_ENTRIES)-1:0] wr_idx,
    input  logic [DATA_BITS-1:0]         wr_data,
    input  logic [$clog2(N_ENTRIES)-1:0] rd_idx,
    output logic [DATA_BITS-1:0]         rd_data
);
    import filter_pkg::*;

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    logic [DATA_BITS-1:0] mem [N_ENTRIES];

    // Address of the next entry to clear during the sweep
    logic [IDX_BITS-1:0] init_idx;

    // Write port after the sweep mux
    logic                 mem_we;
    logic [IDX_BITS-1:0]  mem_waddr;
    logic [DATA_BITS-1:0] mem_wdata;

    // Clearing sweep, one address per cycle after reset
    // rdy rises in the cycle after the last address has been cleared
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            init_idx <= '0;
            rdy <= 1'b0;
        end
        else if (!rdy)
        begin
            init_idx <= init_idx + 1'b1;
            if (init_idx == IDX_BITS'(N_ENTRIES - 1))
            begin
                rdy <= 1'b1;
            end
        end
    end

    // The sweep owns the write port until rdy is high
    always_comb
    begin
        mem_we = wr_en;
        mem_waddr = wr_idx;
        mem_wdata = wr_data;
        if (!rdy)
        begin
            mem_we = 1'b1;
            mem_waddr = init_idx;
            mem_wdata = '0;
        end
    end

    // Registered read returns the old contents when it meets a write
    always_ff @(posedge clk)
    begin
        if (mem_we)
        begin
            mem[mem_waddr] <= mem_wdata;
        end
        rd_data <= mem[rd_idx];
    end

    // The owner of the write bus must hold off until the sweep is over
    assert property (@(posedge clk) disable iff (reset) wr_en |-> rdy)
        else $error("bucket RAM written at %0d during the clearing sweep", wr_idx);

endmodule

/* rtl/remove_fifo.sv */
module remove_fifo
#(
    parameter int DEPTH     = filter_pkg::REMOVE_FIFO_DEPTH_DEFAULT,
    parameter int IDX_BITS  = $clog2(filter_pkg::N_BUCKETS_DEFAULT),
    parameter int MASK_BITS = filter_pkg::BITS_PER_BUCKET_DEFAULT
)
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 enq_en,
    input  logic [IDX_BITS-1:0]  enq_idx,
    input  logic [MASK_BITS-1:0] enq_mask,
    output logic                 not_full,
    input  logic                 deq_en,
    output logic                 not_empty,
    output logic [IDX_BITS-1:0]  first_idx,
    output logic [MASK_BITS-1:0] first_mask
);
    import filter_pkg::*;

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    // Entry storage, an index next to its mask
    logic [IDX_BITS-1:0]  idx_mem [DEPTH];
    logic [MASK_BITS-1:0] mask_mem [DEPTH];

    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;

    // Ring pointer step, DEPTH need not be a power of two
    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        if (ptr == PTR_BITS'(DEPTH - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end
        else
        begin
            if (enq_en)
            begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (deq_en)
            begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // Simultaneous enqueue and dequeue leave the count alone
            if (enq_en && !deq_en)
            begin
                count <= count + 1'b1;
            end
            else if (deq_en && !enq_en)
            begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (enq_en)
        begin
            idx_mem[wr_ptr] <= enq_idx;
            mask_mem[wr_ptr] <= enq_mask;
        end
    end

    assign not_full = (count != CNT_BITS'(DEPTH));
    assign not_empty = (count != '0);

    // Head is shown combinationally, first word falls through
    assign first_idx = idx_mem[rd_ptr];
    assign first_mask = mask_mem[rd_ptr];

    assert property (@(posedge clk) disable iff (reset) enq_en |-> not_full)
        else $error("remove FIFO written while full");
    assert property (@(posedge clk) disable iff (reset) deq_en |-> not_empty)
        else $error("remove FIFO read while empty");

endmodule

/* rtl/update_pipeline.sv */
module update_pipeline
#(
    parameter int N_BUCKETS       = filter_pkg::N_BUCKETS_DEFAULT,
    parameter int BITS_PER_BUCKET = filter_pkg::BITS_PER_BUCKET_DEFAULT
)
(
    input  logic                         clk,
    input  logic                         reset,
    output logic                         upd_rdy,
    input  logic                         insert_en,
    input  logic [$clog2(N_BUCKETS)-1:0] insert_idx,
    input  logic [BITS_PER_BUCKET-1:0]   insert_mask,
    input  logic                         fifo_not_empty,
    input  logic [$clog2(N_BUCKETS)-1:0] fifo_first_idx,
    input  logic [BITS_PER_BUCKET-1:0]   fifo_first_mask,
    output logic                         fifo_deq,
    output logic                         wr_en,
    output logic [$clog2(N_BUCKETS)-1:0] wr_idx,
    output logic [BITS_PER_BUCKET-1:0]   wr_val,
    output logic                         wr_not_zero
);
    import filter_pkg::*;

    localparam int IDX_BITS = $clog2(N_BUCKETS);

    // Two stages past the write are kept so the merge in stage 1 sees
    // every update whose write is not yet visible to the read
    localparam int UPD_LAST = UPD_WRITE_STAGE + 2;

    // ==============================
    // Stage 0, arbitration and read
    // ==============================

    logic                       insert_go;
    logic                       s0_en;
    logic [IDX_BITS-1:0]        s0_idx;
    logic [BITS_PER_BUCKET-1:0] s0_ins;
    logic [BITS_PER_BUCKET-1:0] s0_rem;

    // Insert always wins, the FIFO head only takes idle cycles
    always_comb
    begin
        insert_go = upd_rdy && insert_en;
        fifo_deq = upd_rdy && fifo_not_empty && !insert_en;
        s0_en = insert_go || fifo_deq;
        s0_idx = insert_go ? insert_idx : fifo_first_idx;
        s0_ins = insert_go ? insert_mask : '0;
        s0_rem = fifo_deq ? fifo_first_mask : '0;
    end

    logic [BITS_PER_BUCKET-1:0] upd_rd_val;

    bucket_ram
    #(
        .N_ENTRIES(N_BUCKETS),
        .DATA_BITS(BITS_PER_BUCKET)
    )
    upd_mem
    (
        .clk(clk),
        .reset(reset),
        .rdy(upd_rdy),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_val),
        .rd_idx(s0_idx),
        .rd_data(upd_rd_val)
    );

    // ==============================
    // Stages 1 to 4
    // ==============================

    logic                       upd_en [1:UPD_LAST];
    logic [IDX_BITS-1:0]        upd_idx [1:UPD_LAST];
    logic [BITS_PER_BUCKET-1:0] upd_ins_mask [1:UPD_LAST];
    logic [BITS_PER_BUCKET-1:0] upd_rem_mask [1:UPD_LAST];

    // RAM data lands in stage 1 and is held for the write stage
    logic [BITS_PER_BUCKET-1:0] rd_val_q;

    logic [BITS_PER_BUCKET-1:0] byp_ins_mask;
    logic [BITS_PER_BUCKET-1:0] byp_rem_mask;

    // The youngest matching update already carries all older pending masks
    // Removes are assumed never to follow inserts to a bucket in this window
    always_comb
    begin
        byp_ins_mask = '0;
        byp_rem_mask = '0;
        for (int s = UPD_LAST; s >= 2; s--)
        begin
            if (upd_en[s] && (upd_idx[s] == upd_idx[1]))
            begin
                byp_ins_mask = upd_ins_mask[s];
                byp_rem_mask = upd_rem_mask[s];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int s = 1; s <= UPD_LAST; s++)
            begin
                upd_en[s] <= 1'b0;
            end
        end
        else
        begin
            upd_en[1] <= s0_en;
            for (int s = 2; s <= UPD_LAST; s++)
            begin
                upd_en[s] <= upd_en[s-1];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        upd_idx[1] <= s0_idx;
        upd_ins_mask[1] <= s0_ins;
        upd_rem_mask[1] <= s0_rem;
        for (int s = 2; s <= UPD_LAST; s++)
        begin
            upd_idx[s] <= upd_idx[s-1];
        end
        // Merge point between the read and the write
        upd_ins_mask[UPD_WRITE_STAGE] <= upd_ins_mask[1] | byp_ins_mask;
        upd_rem_mask[UPD_WRITE_STAGE] <= upd_rem_mask[1] | byp_rem_mask;
        for (int s = UPD_WRITE_STAGE + 1; s <= UPD_LAST; s++)
        begin
            upd_ins_mask[s] <= upd_ins_mask[s-1];
            upd_rem_mask[s] <= upd_rem_mask[s-1];
        end
        rd_val_q <= upd_rd_val;
    end

    // Shared write bus feeding every RAM copy
    assign wr_en = upd_en[UPD_WRITE_STAGE];
    assign wr_idx = upd_idx[UPD_WRITE_STAGE];
    assign wr_val = (rd_val_q & ~upd_rem_mask[UPD_WRITE_STAGE]) |
                    upd_ins_mask[UPD_WRITE_STAGE];
    assign wr_not_zero = |wr_val;

    // ==============================
    // Shadow check of the update rule
    // ==============================

    logic [BITS_PER_BUCKET-1:0] shadow [N_BUCKETS];
    logic [BITS_PER_BUCKET-1:0] raw_ins_w;
    logic [BITS_PER_BUCKET-1:0] raw_rem_w;
    logic [BITS_PER_BUCKET-1:0] shadow_next;

    // Unmerged masks of the update at the write stage
    always_ff @(posedge clk)
    begin
        raw_ins_w <= upd_ins_mask[1];
        raw_rem_w <= upd_rem_mask[1];
    end

    assign shadow_next = (shadow[wr_idx] & ~raw_rem_w) | raw_ins_w;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int b = 0; b < N_BUCKETS; b++)
            begin
                shadow[b] <= '0;
            end
        end
        else if (wr_en)
        begin
            shadow[wr_idx] <= shadow_next;
        end
    end

    assert property (@(posedge clk) disable iff (reset) wr_en |-> (wr_val == shadow_next))
        else $error("bucket %0d written with %0h, expected %0h", wr_idx, wr_val, shadow_next);

endmodule

/* rtl/lookup_port.sv */
module lookup_port
#(
    parameter int N_BUCKETS = filter_pkg::N_BUCKETS_DEFAULT,
    parameter int DATA_BITS = filter_pkg::BITS_PER_BUCKET_DEFAULT
)
(
    input  logic                         clk,
    input  logic                         reset,
    input  logic [$clog2(N_BUCKETS)-1:0] req_idx,
    input  logic                         wr_en,
    input  logic [$clog2(N_BUCKETS)-1:0] wr_idx,
    input  logic [DATA_BITS-1:0]         wr_data,
    output logic [DATA_BITS-1:0]         result
);
    import filter_pkg::*;

    localparam int IDX_BITS = $clog2(N_BUCKETS);

    // Stage 0 is the request itself, the result leaves the last stage
    logic [IDX_BITS-1:0]  look_idx [0:LOOKUP_LATENCY];
    logic                 fwd_en [1:LOOKUP_LATENCY];
    logic [DATA_BITS-1:0] fwd_val [1:LOOKUP_LATENCY];

    logic [DATA_BITS-1:0] ram_val;

    assign look_idx[0] = req_idx;

    // The RAM is read one stage before the end, so its one cycle
    // of latency lines the data up with the last stage
    bucket_ram
    #(
        .N_ENTRIES(N_BUCKETS),
        .DATA_BITS(DATA_BITS)
    )
    port_mem
    (
        .clk(clk),
        .reset(reset),
        .rdy(),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_data),
        .rd_idx(look_idx[LOOKUP_LATENCY-1]),
        .rd_data(ram_val)
    );

    // Every stage watches the write bus while the read is in flight
    // A later matching write replaces an earlier forwarded one
    always_ff @(posedge clk)
    begin
        for (int p = 1; p <= LOOKUP_LATENCY; p++)
        begin
            look_idx[p] <= look_idx[p-1];
            if (wr_en && (look_idx[p-1] == wr_idx))
            begin
                fwd_en[p] <= 1'b1;
                fwd_val[p] <= wr_data;
            end
            else if (p == 1)
            begin
                fwd_en[p] <= 1'b0;
            end
            else
            begin
                fwd_en[p] <= fwd_en[p-1];
                fwd_val[p] <= fwd_val[p-1];
            end
        end
        if (reset)
        begin
            for (int p = 1; p <= LOOKUP_LATENCY; p++)
            begin
                fwd_en[p] <= 1'b0;
            end
        end
    end

    // Forwarded data is newer than anything the RAM could return
    assign result = fwd_en[LOOKUP_LATENCY] ? fwd_val[LOOKUP_LATENCY] : ram_val;

endmodule

/* rtl/decode_filter.sv */
module decode_filter
#(
    parameter int N_BUCKETS         = filter_pkg::N_BUCKETS_DEFAULT,
    parameter int BITS_PER_BUCKET   = filter_pkg::BITS_PER_BUCKET_DEFAULT,
    parameter int REMOVE_FIFO_DEPTH = filter_pkg::REMOVE_FIFO_DEPTH_DEFAULT
)
(
    input  logic                         clk,
    input  logic                         reset,
    output logic                         rdy,
    input  logic                         insert_en,
    input  logic [$clog2(N_BUCKETS)-1:0] insert_idx,
    input  logic [BITS_PER_BUCKET-1:0]   insert_mask,
    input  logic                         remove_en,
    input  logic [$clog2(N_BUCKETS)-1:0] remove_idx,
    input  logic [BITS_PER_BUCKET-1:0]   remove_mask,
    output logic                         remove_not_full,
    input  logic [$clog2(N_BUCKETS)-1:0] value_req_idx,
    output logic [BITS_PER_BUCKET-1:0]   value_result,
    input  logic [$clog2(N_BUCKETS)-1:0] zero_req_idx,
    output logic                         is_zero
);
    import filter_pkg::*;

    localparam int IDX_BITS = $clog2(N_BUCKETS);

    // Bucket indexes are plain address bits
    if ((N_BUCKETS & (N_BUCKETS - 1)) != 0)
    begin : g_size_check
        $error("N_BUCKETS must be a power of two");
    end

    // FIFO head toward the update pipeline
    logic                       fifo_not_empty;
    logic [IDX_BITS-1:0]        fifo_first_idx;
    logic [BITS_PER_BUCKET-1:0] fifo_first_mask;
    logic                       fifo_deq;

    // Shared write bus for every RAM copy
    logic                       wr_en;
    logic [IDX_BITS-1:0]        wr_idx;
    logic [BITS_PER_BUCKET-1:0] wr_val;
    logic                       wr_not_zero;

    // The is-zero copy stores a nonzero flag per bucket
    logic zero_result;

    remove_fifo
    #(
        .DEPTH(REMOVE_FIFO_DEPTH),
        .IDX_BITS(IDX_BITS),
        .MASK_BITS(BITS_PER_BUCKET)
    )
    remove_buf
    (
        .clk(clk),
        .reset(reset),
        .enq_en(remove_en),
        .enq_idx(remove_idx),
        .enq_mask(remove_mask),
        .not_full(remove_not_full),
        .deq_en(fifo_deq),
        .not_empty(fifo_not_empty),
        .first_idx(fifo_first_idx),
        .first_mask(fifo_first_mask)
    );

    // The update RAM clears in step with the lookup copies and stands for all
    update_pipeline
    #(
        .N_BUCKETS(N_BUCKETS),
        .BITS_PER_BUCKET(BITS_PER_BUCKET)
    )
    update_pipe
    (
        .clk(clk),
        .reset(reset),
        .upd_rdy(rdy),
        .insert_en(insert_en),
        .insert_idx(insert_idx),
        .insert_mask(insert_mask),
        .fifo_not_empty(fifo_not_empty),
        .fifo_first_idx(fifo_first_idx),
        .fifo_first_mask(fifo_first_mask),
        .fifo_deq(fifo_deq),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_val(wr_val),
        .wr_not_zero(wr_not_zero)
    );

    lookup_port
    #(
        .N_BUCKETS(N_BUCKETS),
        .DATA_BITS(BITS_PER_BUCKET)
    )
    value_port
    (
        .clk(clk),
        .reset(reset),
        .req_idx(value_req_idx),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_val),
        .result(value_result)
    );

    lookup_port
    #(
        .N_BUCKETS(N_BUCKETS),
        .DATA_BITS(1)
    )
    zero_port
    (
        .clk(clk),
        .reset(reset),
        .req_idx(zero_req_idx),
        .wr_en(wr_en),
        .wr_idx(wr_idx),
        .wr_data(wr_not_zero),
        .result(zero_result)
    );

    assign is_zero = ~zero_result;

endmodule

/* testbench/filter_model.svh */
// ==============================
// Reference model of one bank
// ==============================

// Bucket contents after every update issued so far
logic [BITS_PER_BUCKET-1:0] bucket_val [N_BUCKETS];

// Copy of the remove FIFO, the head sits at index 0
logic [IDX_BITS-1:0]        fifo_idx_q [$];
logic [BITS_PER_BUCKET-1:0] fifo_mask_q [$];

// Cycle of the latest insert to each bucket
int last_insert_cycle [N_BUCKETS];

// Lookups in flight, each with the cycle its result is due
logic [BITS_PER_BUCKET-1:0] exp_value_q [$];
logic                       exp_zero_q [$];
int                         due_cycle_q [$];
string                      exp_name_q [$];

task automatic clear_model();
    for (int b = 0; b < N_BUCKETS; b++)
    begin
        bucket_val[b] = '0;
        // Far enough back that no bucket starts inside the guard window
        last_insert_cycle[b] = -100;
    end
    fifo_idx_q.delete();
    fifo_mask_q.delete();
endtask

function automatic bit bucket_in_fifo(input logic [IDX_BITS-1:0] idx);
    foreach (fifo_idx_q[i])
    begin
        if (fifo_idx_q[i] == idx)
        begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

// A remove needs room in the FIFO and must stay clear of recent inserts
function automatic bit remove_allowed(input logic [IDX_BITS-1:0] idx, input bit ins_en,
                                      input logic [IDX_BITS-1:0] ins_idx, input int cycle);
    if (fifo_idx_q.size() >= REMOVE_FIFO_DEPTH)
    begin
        return 1'b0;
    end
    if (ins_en && (ins_idx == idx))
    begin
        return 1'b0;
    end
    return (cycle - last_insert_cycle[idx]) > GUARD_CYCLES;
endfunction

// One cycle of the issue rule, an insert wins and the FIFO head takes idle cycles
task automatic apply_cycle(input logic ins_en, input logic [IDX_BITS-1:0] ins_idx,
                           input logic [BITS_PER_BUCKET-1:0] ins_mask,
                           input logic rem_en, input logic [IDX_BITS-1:0] rem_idx,
                           input logic [BITS_PER_BUCKET-1:0] rem_mask, input int cycle);
    logic [IDX_BITS-1:0]        head_idx;
    logic [BITS_PER_BUCKET-1:0] head_mask;
    if (ins_en)
    begin
        bucket_val[ins_idx] = bucket_val[ins_idx] | ins_mask;
        last_insert_cycle[ins_idx] = cycle;
    end
    else if (fifo_idx_q.size() > 0)
    begin
        head_idx = fifo_idx_q.pop_front();
        head_mask = fifo_mask_q.pop_front();
        bucket_val[head_idx] = bucket_val[head_idx] & ~head_mask;
    end
    // A new entry only reaches the head after this edge
    if (rem_en)
    begin
        fifo_idx_q.push_back(rem_idx);
        fifo_mask_q.push_back(rem_mask);
    end
endtask

/* testbench/decode_filter_tb.sv */
module decode_filter_tb;

    localparam int N_BUCKETS = 16;
    localparam int BITS_PER_BUCKET = 4;
    localparam int REMOVE_FIFO_DEPTH = 4;
    localparam int IDX_BITS = $clog2(N_BUCKETS);

    localparam int CLK_PERIOD = 10;
    localparam int RESET_CYCLES = 5;
    localparam int LOOKUP_CYCLES = 2;
    localparam int GUARD_CYCLES = 4;
    localparam logic [31:0] SEED = 32'h19d1;
    localparam int N_RANDOM_OPS = 2000;
    // Upper bound on the cycles spent in the directed phases
    localparam int N_DIRECTED_OPS = 100;

    logic                       clk;
    logic                       reset;
    logic                       rdy;
    logic                       insert_en;
    logic [IDX_BITS-1:0]        insert_idx;
    logic [BITS_PER_BUCKET-1:0] insert_mask;
    logic                       remove_en;
    logic [IDX_BITS-1:0]        remove_idx;
    logic [BITS_PER_BUCKET-1:0] remove_mask;
    logic                       remove_not_full;
    logic [IDX_BITS-1:0]        value_req_idx;
    logic [BITS_PER_BUCKET-1:0] value_result;
    logic [IDX_BITS-1:0]        zero_req_idx;
    logic                       is_zero;

    int    seed;
    int    cyc;
    string test_name;
    bit    fill_seen;

    `include "filter_model.svh"

    decode_filter
    #(
        .N_BUCKETS(N_BUCKETS),
        .BITS_PER_BUCKET(BITS_PER_BUCKET),
        .REMOVE_FIFO_DEPTH(REMOVE_FIFO_DEPTH)
    )
    DUT
    (
        .clk(clk),
        .reset(reset),
        .rdy(rdy),
        .insert_en(insert_en),
        .insert_idx(insert_idx),
        .insert_mask(insert_mask),
        .remove_en(remove_en),
        .remove_idx(remove_idx),
        .remove_mask(remove_mask),
        .remove_not_full(remove_not_full),
        .value_req_idx(value_req_idx),
        .value_result(value_result),
        .zero_req_idx(zero_req_idx),
        .is_zero(is_zero)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ==============================
    // Compare tasks
    // ==============================

    task automatic check_value(input string name, input logic [BITS_PER_BUCKET-1:0] expected,
                               input logic [BITS_PER_BUCKET-1:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %s: expected %0h, actual %0h", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "bucket value mismatch");
        end
    endtask

    task automatic check_zero(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("ERR %s: expected %0b, actual %0b", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "is_zero mismatch");
        end
    endtask

    task automatic check_not_full(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("ERR %s: expected %0b, actual %0b", name, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "remove_not_full mismatch");
        end
    endtask

    // ==============================
    // Cycle stepping
    // ==============================

    // Waits out the current cycle, then checks its outputs and models its inputs
    // Outputs are read right after the edge, before any flop has moved
    task automatic step_cycle();
        logic  expect_not_full;
        string name;
        expect_not_full = fifo_idx_q.size() < REMOVE_FIFO_DEPTH;
        if (!expect_not_full)
        begin
            fill_seen = 1'b1;
        end
        @(posedge clk);
        check_not_full({test_name, " not_full"}, expect_not_full, remove_not_full);
        while ((due_cycle_q.size() > 0) && (due_cycle_q[0] == cyc))
        begin
            name = exp_name_q.pop_front();
            check_value({name, " value"}, exp_value_q.pop_front(), value_result);
            check_zero({name, " is_zero"}, exp_zero_q.pop_front(), is_zero);
            void'(due_cycle_q.pop_front());
        end
        // The inputs still hold what the DUT saw during this cycle
        apply_cycle(insert_en, insert_idx, insert_mask, remove_en, remove_idx, remove_mask, cyc);
        cyc++;
    endtask

    task automatic run_cycle(input bit ins_en, input logic [IDX_BITS-1:0] ins_idx,
                             input logic [BITS_PER_BUCKET-1:0] ins_mask,
                             input bit rem_en, input logic [IDX_BITS-1:0] rem_idx,
                             input logic [BITS_PER_BUCKET-1:0] rem_mask,
                             input logic [IDX_BITS-1:0] value_idx,
                             input logic [IDX_BITS-1:0] zero_idx);
        insert_en <= ins_en;
        insert_idx <= ins_idx;
        insert_mask <= ins_mask;
        remove_en <= rem_en;
        remove_idx <= rem_idx;
        remove_mask <= rem_mask;
        value_req_idx <= value_idx;
        zero_req_idx <= zero_idx;
        // The model holds exactly the updates issued before this cycle
        exp_value_q.push_back(bucket_val[value_idx]);
        exp_zero_q.push_back(bucket_val[zero_idx] == '0);
        due_cycle_q.push_back(cyc + LOOKUP_CYCLES);
        exp_name_q.push_back(test_name);
        step_cycle();
    endtask

    task automatic idle_cycles(input int n, input logic [IDX_BITS-1:0] value_idx,
                               input logic [IDX_BITS-1:0] zero_idx);
        for (int i = 0; i < n; i++)
        begin
            run_cycle(0, 0, 0, 0, 0, 0, value_idx, zero_idx);
        end
    endtask

    // ==============================
    // Main sequence
    // ==============================

    initial
    begin
        logic [31:0]                rnd;
        logic [31:0]                rnd2;
        bit                         ins_en;
        logic [IDX_BITS-1:0]        ins_idx;
        logic [BITS_PER_BUCKET-1:0] ins_mask;
        bit                         rem_en;
        logic [IDX_BITS-1:0]        rem_idx;
        logic [BITS_PER_BUCKET-1:0] rem_mask;
        logic [IDX_BITS-1:0]        value_idx;
        logic [IDX_BITS-1:0]        zero_idx;

        seed = SEED;
        clk = 1'b0;
        reset = 1'b1;
        insert_en = 1'b0;
        insert_idx = '0;
        insert_mask = '0;
        remove_en = 1'b0;
        remove_idx = '0;
        remove_mask = '0;
        value_req_idx = '0;
        zero_req_idx = '0;
        cyc = 0;
        fill_seen = 1'b0;
        test_name = "reset";
        clear_model();

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        // The RAMs clear one address per cycle and rdy stays low until the last one
        for (int i = 0; i < N_BUCKETS; i++)
        begin
            @(posedge clk);
            if (rdy !== 1'b0)
            begin
                $display("rdy was not low in cycle %0d of the clearing sweep", i);
                $display("=== FAIL ===");
                $fatal(1, "rdy high during the sweep");
            end
        end
        @(posedge clk);
        if (rdy !== 1'b1)
        begin
            $display("rdy did not rise right after the clearing sweep");
            $display("=== FAIL ===");
            $fatal(1, "rdy low after the sweep");
        end

        // Every bucket reads back empty after the sweep
        test_name = "sweep";
        for (int b = 0; b < N_BUCKETS; b++)
        begin
            run_cycle(0, 0, 0, 0, 0, 0, IDX_BITS'(b), IDX_BITS'(N_BUCKETS - 1 - b));
        end

        // Back-to-back inserts to one bucket go through the merge and forwarding paths
        test_name = "insert";
        for (int k = 0; k < BITS_PER_BUCKET; k++)
        begin
            run_cycle(1, 3, BITS_PER_BUCKET'(1 << k), 0, 0, 0, 3, 3);
        end
        run_cycle(1, 10, 4'ha, 0, 0, 0, 3, 10);
        run_cycle(1, 10, 4'h5, 0, 0, 0, 10, 10);
        idle_cycles(6, 10, 3);

        // Removes wait out the inserts to bucket 9 and then clear their bits
        test_name = "remove";
        run_cycle(0, 0, 0, 1, 3, 4'h1, 3, 3);
        run_cycle(0, 0, 0, 1, 3, 4'h4, 3, 3);
        run_cycle(1, 9, 4'h5, 1, 3, 4'h2, 3, 9);
        run_cycle(1, 9, 4'h2, 0, 0, 0, 3, 9);
        idle_cycles(8, 3, 9);

        // An insert every cycle starves the FIFO until it fills up
        test_name = "fill";
        for (int k = 0; k < 10; k++)
        begin
            rem_idx = (k % 2) ? 3 : 9;
            rem_en = remove_allowed(rem_idx, 1'b1, 12, cyc);
            run_cycle(1, 12, BITS_PER_BUCKET'(1 << (k % 4)), rem_en, rem_idx,
                      BITS_PER_BUCKET'(1 << (k % 4)), 12, 9);
        end
        idle_cycles(10, 9, 3);

        test_name = "random";
        for (int n = 0; n < N_RANDOM_OPS; n++)
        begin
            rnd = $random(seed);
            rnd2 = $random(seed);
            // About half the traffic lands on four hot buckets to keep the bypass busy
            ins_idx = rnd[8 +: IDX_BITS];
            if (rnd[1])
            begin
                ins_idx[IDX_BITS-1:2] = '0;
            end
            ins_mask = rnd[12 +: BITS_PER_BUCKET];
            ins_en = rnd[0] && !bucket_in_fifo(ins_idx);
            rem_idx = rnd[16 +: IDX_BITS];
            if (rnd[2])
            begin
                rem_idx[IDX_BITS-1:2] = '0;
            end
            rem_mask = rnd[20 +: BITS_PER_BUCKET];
            rem_en = rnd[3] && remove_allowed(rem_idx, ins_en, ins_idx, cyc);
            // Lookups often hit the bucket that is being updated in the same cycle
            value_idx = rnd2[4] ? ins_idx : rnd2[0 +: IDX_BITS];
            zero_idx = rnd2[5] ? rem_idx : rnd2[8 +: IDX_BITS];
            run_cycle(ins_en, ins_idx, ins_mask, rem_en, rem_idx, rem_mask, value_idx, zero_idx);
        end

        // Let the FIFO empty and the last lookups come back
        test_name = "drain";
        insert_en <= 1'b0;
        remove_en <= 1'b0;
        while ((due_cycle_q.size() > 0) || (fifo_idx_q.size() > 0))
        begin
            step_cycle();
        end

        if (fill_seen)
        begin
            $display("=== PASS ===");
            $finish;
        end
        else
        begin
            $display("remove FIFO never reported full during the insert burst");
            $display("=== FAIL ===");
            $fatal(1, "no back-pressure seen");
        end
    end

    // Twenty cycles per operation plus reset and the clearing sweep
    initial
    begin
        #(CLK_PERIOD * (20 * (N_RANDOM_OPS + N_DIRECTED_OPS) + N_BUCKETS + RESET_CYCLES));
        $display("watchdog expired before the tests finished, the run hung");
        $display("=== FAIL ===");
        $fatal(1, "timeout");
    end

endmodule

/* decode_filter.f */
+incdir+testbench
rtl/filter_pkg.sv
rtl/bucket_ram.sv
rtl/remove_fifo.sv
rtl/update_pipeline.sv
rtl/lookup_port.sv
rtl/decode_filter.sv
testbench/decode_filter_tb.sv
